/* rtl/aes_dec_params.svh */
// AES-128 inverse cipher parameters
// Round and key counts, bus widths and the register map of the slave
`ifndef AES_DEC_PARAMS_SVH
`define AES_DEC_PARAMS_SVH

// ----------------------------------------
// Cipher geometry
// ----------------------------------------
`define AES_NR         4'd10
`define AES_NUM_KEYS   11
`define AES_BLOCK_W    128
`define AES_WORDS      4

// ----------------------------------------
// Wishbone bus
// ----------------------------------------
`define WB_DAT_W       32
`define WB_ADR_W       10

// Byte offsets, all word aligned
`define REG_CTRL       10'h000
`define REG_STATUS     10'h004
`define REG_BLOCK_IN   10'h010
`define REG_BLOCK_OUT  10'h020
// Key k, word w at REG_KEY + 16*k + 4*w
`define REG_KEY        10'h100

// Cycles from ready falling to ready rising
`define AES_LATENCY    51

`endif

/* rtl/aes_state_pkg.sv */
// AES state types
// Byte, column word and the 128-bit state seen as columns or as bytes,
// plus the phase encoding of the round engine
`include "aes_dec_params.svh"

package aes_state_pkg;

  typedef logic [7:0] aes_byte_t;

  // One column of the state
  typedef logic [`AES_BLOCK_W/`AES_WORDS-1:0] aes_word_t;

  // ----------------------------------------
  // State block
  // ----------------------------------------
  // Byte 0 is the MSB, column c is bytes 4c..4c+3, row r of col c is b[4c+r]
  // The S-box path walks col, the shift and mix paths walk b
  typedef union packed {
    aes_word_t [0:`AES_WORDS-1] col;
    aes_byte_t [0:15]           b;
  } aes_state_u;

  // Engine phases
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_INIT,
    PH_SUB,
    PH_MIX
  } round_phase_e;

endpackage

/* rtl/aes_wb_pkg.sv */
// Wishbone side types
// Bus data word and the register select decoded from the address
`include "aes_dec_params.svh"

package aes_wb_pkg;

  typedef logic [`WB_DAT_W-1:0] wb_word_t;

  // ----------------------------------------
  // Register select
  // ----------------------------------------
  // Address decode result, one per register group
  typedef enum logic [2:0] {
    SEL_CTRL,
    SEL_STATUS,
    SEL_BIN,
    SEL_BOUT,
    SEL_KEY,
    // Unmapped, reads zero, still acked
    SEL_NONE
  } reg_sel_e;

endpackage

/* rtl/aes_inv_sbox.sv */
// AES inverse S-box, four lanes
// Combinational lookup of every byte of one column word
`timescale 1ns/10ps

module aes_inv_sbox import aes_state_pkg::*;
(
  input  aes_word_t sword,
  output aes_word_t new_sword
);

  // Table row by high nibble, byte picked by low nibble
  function automatic aes_byte_t inv_sb(input aes_byte_t x);
    logic [127:0] row;
    case (x[7:4])
      4'h0: row = 128'h52096ad53036a538bf40a39e81f3d7fb;
      4'h1: row = 128'h7ce339829b2fff87348e4344c4dee9cb;
      4'h2: row = 128'h547b9432a6c2233dee4c950b42fac34e;
      4'h3: row = 128'h082ea16628d924b2765ba2496d8bd125;
      4'h4: row = 128'h72f8f66486689816d4a45ccc5d65b692;
      4'h5: row = 128'h6c704850fdedb9da5e154657a78d9d84;
      4'h6: row = 128'h90d8ab008cbcd30af7e45805b8b34506;
      4'h7: row = 128'hd02c1e8fca3f0f02c1afbd0301138a6b;
      4'h8: row = 128'h3a9111414f67dcea97f2cfcef0b4e673;
      4'h9: row = 128'h96ac7422e7ad3585e2f937e81c75df6e;
      4'ha: row = 128'h47f11a711d29c5896fb7620eaa18be1b;
      4'hb: row = 128'hfc563e4bc6d279209adbc0fe78cd5af4;
      4'hc: row = 128'h1fdda8338807c731b11210592780ec5f;
      4'hd: row = 128'h60517fa919b54a0d2de57a9f93c99cef;
      4'he: row = 128'ha0e03b4dae2af5b0c8ebbb3c83539961;
      default: row = 128'h172b047eba77d626e169146355210c7d;
    endcase
    // Entry 0 sits in the top byte of the row
    inv_sb = row[8*(15-x[3:0]) +: 8];
  endfunction

  // ----------------------------------------
  // Four parallel lookups
  // ----------------------------------------
  assign new_sword[31:24] = inv_sb(sword[31:24]);
  assign new_sword[23:16] = inv_sb(sword[23:16]);
  assign new_sword[15:8]  = inv_sb(sword[15:8]);
  assign new_sword[7:0]   = inv_sb(sword[7:0]);

endmodule

/* rtl/aes_decipher_round.sv */
// AES-128 decipher round engine
// Initial AddRoundKey, nine full rounds and a final round, one S-box word
// per cycle. Round counter counts down and selects the round key.
`timescale 1ns/10ps
`include "aes_dec_params.svh"

module aes_decipher_round import aes_state_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    start,
  input  aes_state_u              block_in,
  input  logic [`AES_BLOCK_W-1:0] round_key,
  output logic [3:0]              key_idx,
  output aes_state_u              block_out,
  output logic                    ready
);

  // ----------------------------------------
  // GF(2^8) helpers for InvMixColumns
  // ----------------------------------------
  function automatic aes_byte_t gm2(input aes_byte_t x);
    gm2 = {x[6:0], 1'b0} ^ (8'h1b & {8{x[7]}});
  endfunction

  // Factors 9, 11, 13 and 14 from one x2, x4, x8 chain per byte
  function automatic aes_state_u inv_mix_cols(input aes_state_u s);
    aes_byte_t  x1 [0:3];
    aes_byte_t  x2 [0:3];
    aes_byte_t  x4 [0:3];
    aes_byte_t  x8 [0:3];
    aes_byte_t  m9 [0:3];
    aes_byte_t  m11[0:3];
    aes_byte_t  m13[0:3];
    aes_byte_t  m14[0:3];
    aes_state_u r;
    r = s;
    for (int c = 0; c < 4; c++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        x1[i]  = s.b[4*c+i];
        x2[i]  = gm2(x1[i]);
        x4[i]  = gm2(x2[i]);
        x8[i]  = gm2(x4[i]);
        m9[i]  = x8[i] ^ x1[i];
        m11[i] = x8[i] ^ x2[i] ^ x1[i];
        m13[i] = x8[i] ^ x4[i] ^ x1[i];
        m14[i] = x8[i] ^ x4[i] ^ x2[i];
      end
      // Row i gets 14, 11, 13, 9 rotated right by i
      r.b[4*c+0] = m14[0] ^ m11[1] ^ m13[2] ^ m9[3];
      r.b[4*c+1] = m9[0]  ^ m14[1] ^ m11[2] ^ m13[3];
      r.b[4*c+2] = m13[0] ^ m9[1]  ^ m14[2] ^ m11[3];
      r.b[4*c+3] = m11[0] ^ m13[1] ^ m9[2]  ^ m14[3];
    end
    inv_mix_cols = r;
  endfunction

  // Row r rotates right by r columns
  function automatic aes_state_u inv_shift_rows(input aes_state_u s);
    aes_state_u r;
    r = s;
    for (int c = 0; c < 4; c++)
      for (int row = 0; row < 4; row++)
        r.b[4*c+row] = s.b[4*((c-row+4)%4)+row];
    inv_shift_rows = r;
  endfunction

  // ----------------------------------------
  // Registers and datapath nets
  // ----------------------------------------
  round_phase_e phase;
  logic [3:0]   round_ctr;
  logic [1:0]   word_ctr;
  logic         ready_r;
  aes_state_u   block_out_r;
  aes_state_u   state;

  aes_state_u   shifted;
  aes_state_u   sub_src;
  aes_state_u   sub_next;
  aes_state_u   add_rk;
  aes_word_t    sub_word;
  aes_word_t    new_word;

  aes_inv_sbox inv_sbox
  (
    .sword     (sub_word),
    .new_sword (new_word)
  );

  // First S-box cycle also applies the row shift to the whole state
  assign shifted  = inv_shift_rows(state);
  assign sub_src  = (word_ctr == 2'd0) ? shifted : state;
  assign sub_word = sub_src.col[word_ctr];
  assign add_rk   = state ^ round_key;

  // Substituted column goes back in its own slot
  always_comb
  begin
    sub_next               = sub_src;
    sub_next.col[word_ctr] = new_word;
  end

  assign key_idx   = round_ctr;
  assign ready     = ready_r;
  assign block_out = block_out_r;

  // ----------------------------------------
  // Control FSM and counters
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      phase       <= PH_IDLE;
      round_ctr   <= 4'd0;
      word_ctr    <= 2'd0;
      ready_r     <= 1'b1;
      block_out_r <= '0;
    end
    else
    begin
      case (phase)
        PH_IDLE:
        begin
          // Start while busy never reaches here
          if (start)
          begin
            phase     <= PH_INIT;
            round_ctr <= `AES_NR;
            ready_r   <= 1'b0;
          end
        end
        PH_INIT:
        begin
          phase     <= PH_SUB;
          round_ctr <= round_ctr - 4'd1;
          word_ctr  <= 2'd0;
        end
        PH_SUB:
        begin
          // Counter wraps back to 0 for the next round
          word_ctr <= word_ctr + 2'd1;
          if (word_ctr == 2'd3)
            phase <= PH_MIX;
        end
        default:
        begin
          if (round_ctr == 4'd0)
          begin
            // Final round, no InvMixColumns
            phase       <= PH_IDLE;
            ready_r     <= 1'b1;
            block_out_r <= add_rk;
          end
          else
          begin
            phase     <= PH_SUB;
            round_ctr <= round_ctr - 4'd1;
          end
        end
      endcase
    end
  end

  // ----------------------------------------
  // State register
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    case (phase)
      PH_INIT: state <= block_in ^ round_key;
      PH_SUB:  state <= sub_next;
      PH_MIX:  state <= inv_mix_cols(add_rk);
      default: state <= state;
    endcase
  end

endmodule

/* rtl/aes_wb_regs.sv */
// Wishbone classic slave for the AES decipher core
// Holds the round key store, input block, control and status, and reads
// back the output block. Ack is registered, one cycle per access.
`timescale 1ns/10ps
`include "aes_dec_params.svh"

module aes_wb_regs import aes_state_pkg::*, aes_wb_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [`WB_ADR_W-1:0]    wb_adr,
  input  wb_word_t                wb_dat_w,
  output wb_word_t                wb_dat_r,
  output logic                    wb_ack,
  input  logic                    ready,
  input  aes_state_u              block_out,
  input  logic [3:0]              key_idx,
  output logic                    start,
  output aes_state_u              block_in,
  output logic [`AES_BLOCK_W-1:0] round_key
);

  reg_sel_e              sel;
  logic [`WB_ADR_W-1:0]  key_off;
  logic [3:0]            key_sel;
  logic [1:0]            word_sel;
  logic                  access;
  logic                  wr;
  wb_word_t              rd_data;

  logic                  ack_r;
  logic                  start_r;
  wb_word_t              dat_r;
  aes_state_u            block_in_r;
  aes_state_u            key_mem [0:`AES_NUM_KEYS-1];

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign key_off  = wb_adr - `REG_KEY;
  assign key_sel  = key_off[7:4];
  assign word_sel = wb_adr[3:2];

  always_comb
  begin
    if (wb_adr == `REG_CTRL)
      sel = SEL_CTRL;
    else if (wb_adr == `REG_STATUS)
      sel = SEL_STATUS;
    else if (wb_adr[9:4] == `REG_BLOCK_IN >> 4)
      sel = SEL_BIN;
    else if (wb_adr[9:4] == `REG_BLOCK_OUT >> 4)
      sel = SEL_BOUT;
    // Key window is 16 bytes per key above REG_KEY
    else if (key_off[9:8] == 2'b00 && key_sel < `AES_NUM_KEYS)
      sel = SEL_KEY;
    else
      sel = SEL_NONE;
  end

  // New access only when ack is not already up
  assign access = wb_cyc && wb_stb && !ack_r;
  assign wr     = access && wb_we;

  // Read mux
  always_comb
  begin
    case (sel)
      SEL_STATUS: rd_data = {{(`WB_DAT_W-1){1'b0}}, ready};
      SEL_BIN:    rd_data = block_in_r.col[word_sel];
      SEL_BOUT:   rd_data = block_out.col[word_sel];
      SEL_KEY:    rd_data = key_mem[key_sel].col[word_sel];
      // Start bit self clears, CTRL reads zero
      default:    rd_data = '0;
    endcase
  end

  // ----------------------------------------
  // Bus handshake and register writes
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ack_r      <= 1'b0;
      start_r    <= 1'b0;
      dat_r      <= '0;
      block_in_r <= '0;
      for (int k = 0; k < `AES_NUM_KEYS; k++)
        key_mem[k] <= '0;
    end
    else
    begin
      ack_r   <= access;
      // Pulse lines up with the ack edge
      start_r <= wr && (sel == SEL_CTRL) && wb_dat_w[0];
      if (access)
        dat_r <= rd_data;
      // Operands are frozen while an operation runs
      if (wr && ready && sel == SEL_BIN)
        block_in_r.col[word_sel] <= wb_dat_w;
      if (wr && ready && sel == SEL_KEY)
        key_mem[key_sel].col[word_sel] <= wb_dat_w;
    end
  end

  assign wb_ack   = ack_r;
  assign wb_dat_r = dat_r;
  assign start    = start_r;
  assign block_in = block_in_r;

  // Engine never asks past key 10
  assign round_key = (key_idx < `AES_NUM_KEYS) ? key_mem[key_idx] : '0;

endmodule

/* rtl/aes_dec_top.sv */
// AES-128 decipher core with Wishbone classic slave
// Bus register block in front of the word-serial round engine
`timescale 1ns/10ps
`include "aes_dec_params.svh"

module aes_dec_top import aes_state_pkg::*, aes_wb_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [`WB_ADR_W-1:0] wb_adr,
  input  wb_word_t             wb_dat_w,
  output wb_word_t             wb_dat_r,
  output logic                 wb_ack
);

  // ----------------------------------------
  // Regs to engine
  // ----------------------------------------
  logic                    start;
  logic                    ready;
  logic [3:0]              key_idx;
  logic [`AES_BLOCK_W-1:0] round_key;
  aes_state_u              block_in;
  aes_state_u              block_out;

  aes_wb_regs regs
  (
    .clk       (clk),
    .reset_n   (reset_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .ready     (ready),
    .block_out (block_out),
    .key_idx   (key_idx),
    .start     (start),
    .block_in  (block_in),
    .round_key (round_key)
  );

  // Key store read is combinational on key_idx
  aes_decipher_round engine
  (
    .clk       (clk),
    .reset_n   (reset_n),
    .start     (start),
    .block_in  (block_in),
    .round_key (round_key),
    .key_idx   (key_idx),
    .block_out (block_out),
    .ready     (ready)
  );

endmodule

/* verif/aes_dec_properties.sv */
// Protocol assertions for the AES decipher core
// Wishbone ack rules and the start to ready timing of the round engine
`timescale 1ns/10ps
`include "aes_dec_params.svh"

module aes_dec_properties
(
  input logic clk,
  input logic reset_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic start,
  input logic ready
);

  // Cycles spent with ready low
  logic [6:0] busy_cnt;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      busy_cnt <= 7'd0;
    else if (!ready)
      busy_cnt <= busy_cnt + 7'd1;
    else
      busy_cnt <= 7'd0;
  end

  // ----------------------------------------
  // Bus handshake
  // ----------------------------------------
  ack_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("ack raised outside a bus cycle");

  ack_single: assert property (@(posedge clk) disable iff (!reset_n)
    wb_ack |=> !wb_ack)
    else $error("ack high for two cycles");

  // Engine timing
  start_busy: assert property (@(posedge clk) disable iff (!reset_n)
    start |=> !ready)
    else $error("ready still high after start");

  busy_length: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(ready) |-> (busy_cnt == 7'(`AES_LATENCY)))
    else $error("ready low for the wrong number of cycles");

endmodule

bind aes_dec_top aes_dec_properties props
(
  .clk     (clk),
  .reset_n (reset_n),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .wb_ack  (wb_ack),
  .start   (start),
  .ready   (ready)
);

/* verif/aes_dec_tb.sv */
// AES-128 inverse cipher testbench
// Drives the Wishbone slave, loads round keys and blocks, and compares
// every result with a reference inverse cipher built on GF(2^8) math
`timescale 1ns/10ps
`include "aes_dec_params.svh"

module aes_dec_tb;

  localparam int CLK_NS = 40;
  // Readback pass and busy test are counted as operations too
  localparam int NUM_OPS = 24;
  localparam int TIMEOUT_NS = NUM_OPS * (`AES_LATENCY + 120) * CLK_NS * 2;

  typedef logic [0:`AES_NUM_KEYS-1][127:0] key_set_t;

  logic        clk;
  logic        reset_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [9:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  integer       seed = 32'h9aaa_c887;
  int           errors = 0;
  int           pending = 0;
  int           busy_cycles = 0;
  int           low_cnt = 0;
  logic [127:0] exp_q [$];
  string        name_q [$];
  logic [7:0]   inv_sbox_tb [0:255];

  aes_dec_top uut
  (
    .clk      (clk),
    .reset_n  (reset_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS/2) clk = ~clk;
  end

  // ----------------------------------------
  // GF(2^8) math and reference model
  // ----------------------------------------
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        p = p ^ x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // a^254 is the inverse, zero maps to zero
  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] r;
    r = 8'h01;
    for (int i = 0; i < 254; i++)
      r = gf_mul(r, a);
    return r;
  endfunction

  function automatic logic [7:0] rotl8(input logic [7:0] x, input int n);
    logic [15:0] t;
    t = {x, x} << n;
    return t[15:8];
  endfunction

  // Inverse affine map first, then field inversion
  task automatic build_inv_sbox();
    logic [7:0] b;
    for (int v = 0; v < 256; v++)
    begin
      b = rotl8(8'(v), 1) ^ rotl8(8'(v), 3) ^ rotl8(8'(v), 6) ^ 8'h05;
      inv_sbox_tb[v] = gf_inv(b);
    end
  endtask

  // Byte 0 is the MSB, column c holds bytes 4c..4c+3
  function automatic logic [127:0] ref_decrypt(input logic [127:0] blk, input key_set_t ks);
    logic [127:0] s;
    logic [127:0] t;
    logic [7:0]   a [0:3];
    logic [7:0]   coef [0:3];
    logic [7:0]   acc;
    coef[0] = 8'd14;
    coef[1] = 8'd11;
    coef[2] = 8'd13;
    coef[3] = 8'd9;
    s = blk ^ ks[10];
    for (int r = 9; r >= 0; r--)
    begin
      // InvShiftRows and InvSubBytes together
      for (int c = 0; c < 4; c++)
        for (int row = 0; row < 4; row++)
          t[127-8*(4*c+row) -: 8] = inv_sbox_tb[s[127-8*(4*((c-row+4)%4)+row) -: 8]];
      s = t ^ ks[r];
      if (r > 0)
      begin
        // InvMixColumns, coefficient row rotated by row index
        for (int c = 0; c < 4; c++)
        begin
          for (int i = 0; i < 4; i++)
            a[i] = s[127-8*(4*c+i) -: 8];
          for (int row = 0; row < 4; row++)
          begin
            acc = 8'h00;
            for (int i = 0; i < 4; i++)
              acc = acc ^ gf_mul(a[i], coef[(i-row+4)%4]);
            t[127-8*(4*c+row) -: 8] = acc;
          end
        end
        s = t;
      end
    end
    return s;
  endfunction

  // ----------------------------------------
  // Bus access and checking
  // ----------------------------------------
  task automatic check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act)
    begin
      $display("mismatch %s expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic wb_write(input logic [9:0] adr, input logic [31:0] dat);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    // Ack sampled at the falling edge
    do
      @(negedge clk);
    while (!wb_ack);
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [9:0] adr, output logic [31:0] dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do
      @(negedge clk);
    while (!wb_ack);
    dat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic random_keys(output key_set_t ks);
    for (int k = 0; k < `AES_NUM_KEYS; k++)
      for (int w = 0; w < 4; w++)
        ks[k][127-32*w -: 32] = $random(seed);
  endtask

  task automatic random_block(output logic [127:0] blk);
    for (int w = 0; w < 4; w++)
      blk[127-32*w -: 32] = $random(seed);
  endtask

  task automatic load_keys(input key_set_t ks);
    for (int k = 0; k < `AES_NUM_KEYS; k++)
      for (int w = 0; w < 4; w++)
        wb_write(10'(`REG_KEY + 16*k + 4*w), ks[k][127-32*w -: 32]);
  endtask

  task automatic load_block(input logic [127:0] blk);
    for (int w = 0; w < 4; w++)
      wb_write(10'(`REG_BLOCK_IN + 4*w), blk[127-32*w -: 32]);
  endtask

  task automatic verify_operands(input string name, input key_set_t ks, input logic [127:0] blk);
    logic [31:0] d;
    for (int k = 0; k < `AES_NUM_KEYS; k++)
      for (int w = 0; w < 4; w++)
      begin
        wb_read(10'(`REG_KEY + 16*k + 4*w), d);
        check_value({name, "_key"}, 128'(ks[k][127-32*w -: 32]), 128'(d));
      end
    for (int w = 0; w < 4; w++)
    begin
      wb_read(10'(`REG_BLOCK_IN + 4*w), d);
      check_value({name, "_block_in"}, 128'(blk[127-32*w -: 32]), 128'(d));
    end
  endtask

  // Hand the expected result to the compare process and wait for it
  task automatic queue_expected(input string name, input logic [127:0] exp);
    exp_q.push_back(exp);
    name_q.push_back(name);
    pending++;
    wait (pending == 0);
  endtask

  task automatic run_decrypt(input string name, input key_set_t ks, input logic [127:0] blk,
                             input logic new_keys);
    if (new_keys)
      load_keys(ks);
    load_block(blk);
    wb_write(`REG_CTRL, 32'h1);
    queue_expected(name, ref_decrypt(blk, ks));
  endtask

  // Busy length of the engine, from ready falling to ready rising
  always @(negedge clk)
  begin
    if (uut.ready === 1'b0)
      low_cnt++;
    else if (low_cnt != 0)
    begin
      busy_cycles = low_cnt;
      low_cnt = 0;
    end
  end

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  initial
  begin : compare_proc
    logic [31:0]  d;
    logic [127:0] got;
    forever
    begin
      wait (pending > 0);
      d = 32'h0;
      while (d[0] == 1'b0)
        wb_read(`REG_STATUS, d);
      for (int w = 0; w < 4; w++)
      begin
        wb_read(10'(`REG_BLOCK_OUT + 4*w), d);
        got[127-32*w -: 32] = d;
      end
      check_value(name_q[0], exp_q[0], got);
      check_value({name_q[0], "_latency"}, 128'(`AES_LATENCY), 128'(busy_cycles));
      void'(exp_q.pop_front());
      void'(name_q.pop_front());
      pending--;
    end
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS);
    $display("simulation timed out after %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial
  begin : stimulus
    key_set_t     ks;
    logic [127:0] blk;
    logic [31:0]  d;
    reset_n  <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    build_inv_sbox();
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    // Reset values
    wb_read(`REG_STATUS, d);
    check_value("reset_status", 128'd1, 128'(d));
    for (int w = 0; w < 4; w++)
    begin
      wb_read(10'(`REG_BLOCK_OUT + 4*w), d);
      check_value("reset_block_out", 128'd0, 128'(d));
    end

    // Operand readback
    random_keys(ks);
    random_block(blk);
    load_keys(ks);
    load_block(blk);
    verify_operands("readback", ks, blk);

    // One decryption, latency checked by the compare process
    random_keys(ks);
    random_block(blk);
    run_decrypt("single", ks, blk, 1'b1);

    // Stream of blocks, fresh keys every fifth
    for (int i = 0; i < 20; i++)
    begin
      if (i % 5 == 0)
        random_keys(ks);
      random_block(blk);
      run_decrypt($sformatf("stream_%0d", i), ks, blk, i % 5 == 0);
    end

    // Writes while busy must all be dropped
    random_keys(ks);
    random_block(blk);
    load_keys(ks);
    load_block(blk);
    wb_write(`REG_CTRL, 32'h1);
    wb_write(`REG_CTRL, 32'h1);
    wb_write(10'(`REG_KEY + 16*10), $random(seed));
    wb_write(10'(`REG_KEY + 12), $random(seed));
    wb_write(`REG_BLOCK_IN, $random(seed));
    wb_write(10'(`REG_BLOCK_IN + 12), $random(seed));
    queue_expected("busy_writes", ref_decrypt(blk, ks));
    verify_operands("busy_readback", ks, blk);

    $display("checks done, %0d errors", errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+rtl
rtl/aes_state_pkg.sv
rtl/aes_wb_pkg.sv
rtl/aes_inv_sbox.sv
rtl/aes_decipher_round.sv
rtl/aes_wb_regs.sv
rtl/aes_dec_top.sv
verif/aes_dec_properties.sv
verif/aes_dec_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the AES decipher testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module aes_dec_tb \
  -o aes_dec_sim || exit 1
out=$(./obj_dir/aes_dec_sim)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1
